//--- logic/tile_pkg.sv
`default_nettype none

package tile_pkg;

    // map geometry
    localparam int TILE_COLS = 40;
    localparam int TILE_ROWS = 30;
    localparam int TILE_PX   = 16;  // pixels per tile side

    localparam int FLOOR_ROW_FIRST = 27;
    localparam int FLOOR_ROWS      = 3;

    typedef logic [10:0] tile_addr_t;  // row * TILE_COLS + col
    typedef logic [6:0]  tile_col_t;   // may run past the right edge
    typedef logic [4:0]  tile_row_t;

    // one background map entry, bit 8 down to bit 0
    typedef struct packed {
        logic       en;
        logic       y_flip;
        logic       x_flip;
        logic [2:0] sheet_row;
        logic [2:0] sheet_col;
    } tile_word_t;

    typedef struct packed {
        tile_addr_t addr;
        tile_word_t word;
    } tile_write_t;

    // sprite sheet entries
    localparam tile_word_t TILE_BLANK       = '0;
    localparam tile_word_t FLOOR_TOP        = '{1'b1, 1'b0, 1'b0, 3'd6, 3'd0};
    localparam tile_word_t FLOOR_FILL       = '{1'b1, 1'b0, 1'b0, 3'd6, 3'd3};
    localparam tile_word_t CLIFF_LEFT_TOP   = '{1'b1, 1'b0, 1'b0, 3'd6, 3'd1};
    localparam tile_word_t CLIFF_LEFT_BODY  = '{1'b1, 1'b0, 1'b0, 3'd7, 3'd0};
    localparam tile_word_t CLIFF_RIGHT_TOP  = '{1'b1, 1'b0, 1'b1, 3'd6, 3'd1};  // mirrored
    localparam tile_word_t CLIFF_RIGHT_BODY = '{1'b1, 1'b0, 1'b1, 3'd7, 3'd0};
    localparam tile_word_t COIN_TILE        = '{1'b1, 1'b0, 1'b0, 3'd7, 3'd4};
    localparam tile_word_t GHOST_TILE       = '{1'b1, 1'b0, 1'b1, 3'd6, 3'd7};

endpackage

`default_nettype wire

//--- logic/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef logic [15:0] score_t;

    // top-left corner of the player box, in screen pixels
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } player_pos_t;

    localparam int PLAYER_W = 16;
    localparam int PLAYER_H = 32;

    // scroll speed, in clock cycles per pixel step
    localparam int SCROLL_DELAY_START = 60;
    localparam int SCROLL_DELAY_MIN   = 24;
    localparam int SCROLL_SPEED_STEP  = 12;
    localparam int SPEEDUP_EVERY      = 10;  // score points per speed-up

    localparam int COIN_POINTS = 1;
    localparam int FALL_Y      = 480;

    localparam logic [7:0] CLIFF_LFSR_SEED = 8'hb5;
    localparam logic [7:0] COIN_LFSR_SEED  = 8'ha6;
    localparam logic [7:0] GHOST_LFSR_SEED = 8'h5d;

    localparam int CLIFF_COL_START = 20;

    // sprite placement
    localparam int GHOST_ROW      = 26;
    localparam int GHOST_COL_SPAN = 5;
    localparam int COIN_ROW_BASE  = 23;
    localparam int COIN_ROW_SPAN  = 4;
    localparam int COIN_COL_SPAN  = 6;

endpackage

`default_nettype wire

//--- logic/scroll_timer.sv
`default_nettype none

module scroll_timer (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   game_on,
    input  wire                   game_over,
    input  wire game_pkg::score_t score,
    output logic [3:0]            fine_offset,
    output logic                  tile_step
);

    logic [7:0] count;
    logic [7:0] delay;       // delay of the step now running
    logic [7:0] next_delay;
    logic       running;
    logic       scroll_step;
    int         speedups;

    assign running     = game_on && !game_over;
    assign scroll_step = running && (count == delay);

    // speed-up rule, floored at the minimum delay
    always_comb begin
        speedups = int'(score) / game_pkg::SPEEDUP_EVERY;
        if (speedups * game_pkg::SCROLL_SPEED_STEP >=
            game_pkg::SCROLL_DELAY_START - game_pkg::SCROLL_DELAY_MIN) begin
            next_delay = 8'(game_pkg::SCROLL_DELAY_MIN);
        end else begin
            next_delay = 8'(game_pkg::SCROLL_DELAY_START
                            - speedups * game_pkg::SCROLL_SPEED_STEP);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count       <= '0;
            delay       <= 8'(game_pkg::SCROLL_DELAY_START);
            fine_offset <= '0;
            tile_step   <= 1'b0;
        end else begin
            tile_step <= 1'b0;
            if (scroll_step) begin
                count       <= '0;
                delay       <= next_delay;  // new speed starts here
                fine_offset <= fine_offset + 4'd1;
                tile_step   <= (fine_offset == 4'(tile_pkg::TILE_PX - 1));
            end else if (running) begin
                count <= count + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/floor_painter.sv
`default_nettype none

module floor_painter (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   game_on,
    input  wire                   game_over,
    input  wire                   tile_step,
    output logic                  req,
    input  wire                   ack,
    output tile_pkg::tile_write_t wr
);

    tile_pkg::tile_col_t  cliff;    // gap covers cliff-4 .. cliff-1
    tile_pkg::tile_col_t  gap_col;  // cliff frozen for the sweep in progress
    tile_pkg::tile_word_t tile;
    logic [7:0]           lfsr;
    logic [5:0]           sw_col;
    logic [1:0]           sw_row;
    logic                 busy;
    logic                 pending;
    logic                 running;
    int                   col_i;
    int                   gap_i;

    assign running = game_on && !game_over;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr  <= game_pkg::CLIFF_LFSR_SEED;
            cliff <= tile_pkg::tile_col_t'(game_pkg::CLIFF_COL_START);
        end else if (running) begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5]};
            if (tile_step) begin
                if (cliff == '0) begin
                    cliff <= tile_pkg::tile_col_t'(tile_pkg::TILE_COLS + lfsr[5:0]);
                end else begin
                    cliff <= cliff - 1'b1;
                end
            end
        end
    end

    // sweep sequencer, one handshake per floor tile
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req     <= 1'b0;
            busy    <= 1'b0;
            pending <= 1'b1;  // paint the floor once after reset
            sw_col  <= '0;
            sw_row  <= '0;
            gap_col <= '0;
        end else begin
            if (!busy) begin
                if (pending) begin
                    busy    <= 1'b1;
                    pending <= 1'b0;
                    sw_col  <= '0;
                    sw_row  <= '0;
                    gap_col <= cliff;
                end
            end else if (req) begin
                if (ack) begin
                    req <= 1'b0;
                    if (sw_col == 6'(tile_pkg::TILE_COLS - 1)) begin
                        sw_col <= '0;
                        sw_row <= sw_row + 2'd1;
                    end else begin
                        sw_col <= sw_col + 6'd1;
                    end
                end
            end else if (!ack) begin
                if (sw_row == 2'(tile_pkg::FLOOR_ROWS)) begin
                    busy <= 1'b0;  // last row done
                end else begin
                    req <= 1'b1;
                end
            end
            if (tile_step) begin
                pending <= 1'b1;
            end
        end
    end

    always_comb begin
        col_i = int'(sw_col);
        gap_i = int'(gap_col);
        if (col_i == gap_i - 4) begin
            tile = (sw_row == '0) ? tile_pkg::CLIFF_LEFT_TOP : tile_pkg::CLIFF_LEFT_BODY;
        end else if (col_i == gap_i - 3 || col_i == gap_i - 2) begin
            tile = tile_pkg::TILE_BLANK;
        end else if (col_i == gap_i - 1) begin
            tile = (sw_row == '0) ? tile_pkg::CLIFF_RIGHT_TOP : tile_pkg::CLIFF_RIGHT_BODY;
        end else begin
            tile = (sw_row == '0) ? tile_pkg::FLOOR_TOP : tile_pkg::FLOOR_FILL;
        end
    end

    assign wr.addr = tile_pkg::tile_addr_t'((tile_pkg::FLOOR_ROW_FIRST + sw_row)
                                            * tile_pkg::TILE_COLS + sw_col);
    assign wr.word = tile;

endmodule

`default_nettype wire

//--- logic/sprite_mover.sv
`default_nettype none

module sprite_mover #(
    parameter tile_pkg::tile_word_t SPRITE    = tile_pkg::COIN_TILE,
    parameter int                   ROW_BASE  = 23,
    parameter int                   ROW_SPAN  = 4,
    parameter int                   COL_SPAN  = 6,
    parameter logic [7:0]           LFSR_SEED = 8'ha6
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   game_on,
    input  wire                   game_over,
    input  wire                   tile_step,
    input  wire                   hide,
    output tile_pkg::tile_col_t   col,
    output tile_pkg::tile_row_t   row,
    output logic                  req,
    input  wire                   ack,
    output tile_pkg::tile_write_t wr
);

    tile_pkg::tile_addr_t cur_addr;
    tile_pkg::tile_addr_t erase_addr;
    logic [7:0]           lfsr;
    logic                 hide_q;
    logic                 hidden;
    logic                 pend_erase;
    logic                 pend_draw;
    logic                 running;
    logic                 on_screen;

    assign running   = game_on && !game_over;
    assign on_screen = col < tile_pkg::TILE_COLS;
    assign cur_addr  = tile_pkg::tile_addr_t'(row * tile_pkg::TILE_COLS + col);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr       <= LFSR_SEED;
            col        <= tile_pkg::tile_col_t'(tile_pkg::TILE_COLS - 1);
            row        <= tile_pkg::tile_row_t'(ROW_BASE);
            hide_q     <= 1'b0;
            hidden     <= 1'b0;
            pend_erase <= 1'b0;
            pend_draw  <= 1'b0;
            erase_addr <= '0;
            req        <= 1'b0;
            wr         <= '0;
        end else begin
            hide_q <= hide;
            if (running) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5]};
            end

            // launch the next write once the last handshake has closed
            if (!req && !ack) begin
                if (pend_erase) begin
                    wr         <= '{addr: erase_addr, word: tile_pkg::TILE_BLANK};
                    req        <= 1'b1;
                    pend_erase <= 1'b0;
                end else if (pend_draw) begin
                    pend_draw <= 1'b0;
                    if (on_screen && !hidden) begin
                        wr  <= '{addr: cur_addr, word: SPRITE};
                        req <= 1'b1;
                    end
                end
            end else if (req && ack) begin
                req <= 1'b0;
            end

            if (hide && !hide_q) begin
                hidden <= 1'b1;
                if (!pend_erase && on_screen) begin  // blank whatever is drawn now
                    pend_erase <= 1'b1;
                    erase_addr <= cur_addr;
                end
            end

            if (tile_step && running) begin
                if (on_screen) begin
                    pend_erase <= 1'b1;
                    erase_addr <= cur_addr;
                end
                pend_draw <= 1'b1;
                if (col == '0) begin
                    col    <= tile_pkg::tile_col_t'(tile_pkg::TILE_COLS - 1 - lfsr % COL_SPAN);
                    row    <= tile_pkg::tile_row_t'(ROW_BASE + lfsr % ROW_SPAN);
                    hidden <= 1'b0;
                end else begin
                    col <= col - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/collision_judge.sv
`default_nettype none

module collision_judge (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        game_on,
    input  wire game_pkg::player_pos_t player,
    input  wire [3:0]                  fine_offset,
    input  wire tile_pkg::tile_col_t   coin_col,
    input  wire tile_pkg::tile_row_t   coin_row,
    input  wire tile_pkg::tile_col_t   ghost_col,
    input  wire tile_pkg::tile_row_t   ghost_row,
    output logic                       coin_eaten,
    output game_pkg::score_t           score,
    output logic                       game_over
);

    tile_pkg::tile_col_t coin_col_q;
    logic                coin_hit;
    logic                ghost_hit;
    logic                fell;

    // player box against one tile, both in scrolled map pixels
    function automatic logic box_hit(input game_pkg::player_pos_t p, input logic [3:0] off,
                                     input tile_pkg::tile_col_t c, input tile_pkg::tile_row_t r);
        int px;
        int tx;
        int ty;
        px = int'(p.x) + int'(off);
        tx = int'(c) * tile_pkg::TILE_PX;
        ty = int'(r) * tile_pkg::TILE_PX;
        return (px + game_pkg::PLAYER_W >= tx) && (px < tx + tile_pkg::TILE_PX) &&
               (int'(p.y) + game_pkg::PLAYER_H >= ty) && (int'(p.y) <= ty + tile_pkg::TILE_PX);
    endfunction

    assign coin_hit  = box_hit(player, fine_offset, coin_col, coin_row);
    assign ghost_hit = box_hit(player, fine_offset, ghost_col, ghost_row);
    assign fell      = player.y >= 10'(game_pkg::FALL_Y);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            coin_col_q <= '0;
            coin_eaten <= 1'b0;
            score      <= '0;
            game_over  <= 1'b0;
        end else begin
            coin_col_q <= coin_col;
            if (coin_col_q == '0 && coin_col != '0) begin
                coin_eaten <= 1'b0;  // fresh coin after respawn
            end
            if (game_on && !game_over) begin
                if (coin_hit && !coin_eaten) begin
                    score      <= score + game_pkg::score_t'(game_pkg::COIN_POINTS);
                    coin_eaten <= 1'b1;
                end
                if (ghost_hit || fell) begin
                    game_over <= 1'b1;  // sticky until reset
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/bg_write_arbiter.sv
`default_nettype none

module bg_write_arbiter #(
    parameter int N_PORTS = 3
) (
    input  wire                        clk,
    input  wire                        reset,
    input  wire [N_PORTS-1:0]          req,
    input  wire tile_pkg::tile_write_t wr [N_PORTS],
    output logic [N_PORTS-1:0]         ack,
    output logic                       bg_we,
    output tile_pkg::tile_write_t      bg_write
);

    localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    typedef enum logic {
        ARB_IDLE,
        ARB_HOLD  // ack high, waiting for the peer to drop req
    } arb_state_t;

    arb_state_t       state;
    logic [IDX_W-1:0] ptr;   // first port to look at
    logic [IDX_W-1:0] gnt;
    logic [IDX_W-1:0] pick;
    logic             found;
    int               idx;

    // round-robin search starting at ptr
    always_comb begin
        pick  = ptr;
        found = 1'b0;
        idx   = 0;
        for (int i = 0; i < N_PORTS; i++) begin
            idx = (int'(ptr) + i) % N_PORTS;
            if (!found && req[idx]) begin
                pick  = IDX_W'(idx);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ARB_IDLE;
            ptr   <= '0;
            gnt   <= '0;
            ack   <= '0;
            bg_we <= 1'b0;
        end else begin
            bg_we <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        gnt   <= pick;
                        ack   <= N_PORTS'(1) << pick;
                        bg_we <= 1'b1;  // single-cycle write strobe
                        ptr   <= (pick == IDX_W'(N_PORTS - 1)) ? '0 : pick + 1'b1;
                        state <= ARB_HOLD;
                    end
                end
                ARB_HOLD: begin
                    if (!req[gnt]) begin
                        ack   <= '0;
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && found) begin
            bg_write <= wr[pick];
        end
    end

endmodule

`default_nettype wire

//--- logic/game_engine.sv
`default_nettype none

module game_engine (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        game_on,
    input  wire game_pkg::player_pos_t player,
    output logic                       bg_we,
    output tile_pkg::tile_write_t      bg_write,
    output logic [3:0]                 bg_x_offset,
    output game_pkg::score_t           score,
    output logic                       game_over
);

    logic [3:0]          fine_offset;
    logic                tile_step;
    logic                coin_eaten;
    tile_pkg::tile_col_t coin_col;
    tile_pkg::tile_row_t coin_row;
    tile_pkg::tile_col_t ghost_col;
    tile_pkg::tile_row_t ghost_row;

    // arbiter ports: 0 floor, 1 coin, 2 ghost
    wire [2:0]                  peer_req;
    wire [2:0]                  peer_ack;
    wire tile_pkg::tile_write_t peer_wr [3];

    assign bg_x_offset = game_over ? 4'd0 : fine_offset;  // screen stops on game over

    scroll_timer u_scroll (
        .clk, .reset, .game_on, .game_over, .score, .fine_offset, .tile_step
    );

    floor_painter u_floor (
        .clk, .reset, .game_on, .game_over, .tile_step,
        .req(peer_req[0]), .ack(peer_ack[0]), .wr(peer_wr[0])
    );

    sprite_mover #(
        .SPRITE(tile_pkg::COIN_TILE), .ROW_BASE(game_pkg::COIN_ROW_BASE),
        .ROW_SPAN(game_pkg::COIN_ROW_SPAN), .COL_SPAN(game_pkg::COIN_COL_SPAN),
        .LFSR_SEED(game_pkg::COIN_LFSR_SEED)
    ) u_coin (
        .clk, .reset, .game_on, .game_over, .tile_step, .hide(coin_eaten),
        .col(coin_col), .row(coin_row),
        .req(peer_req[1]), .ack(peer_ack[1]), .wr(peer_wr[1])
    );

    sprite_mover #(
        .SPRITE(tile_pkg::GHOST_TILE), .ROW_BASE(game_pkg::GHOST_ROW), .ROW_SPAN(1),
        .COL_SPAN(game_pkg::GHOST_COL_SPAN), .LFSR_SEED(game_pkg::GHOST_LFSR_SEED)
    ) u_ghost (
        .clk, .reset, .game_on, .game_over, .tile_step, .hide(1'b0),
        .col(ghost_col), .row(ghost_row),
        .req(peer_req[2]), .ack(peer_ack[2]), .wr(peer_wr[2])
    );

    collision_judge u_judge (
        .clk, .reset, .game_on, .player, .fine_offset,
        .coin_col, .coin_row, .ghost_col, .ghost_row,
        .coin_eaten, .score, .game_over
    );

    bg_write_arbiter #(
        .N_PORTS(3)
    ) u_arb (
        .clk, .reset, .req(peer_req), .wr(peer_wr), .ack(peer_ack), .bg_we, .bg_write
    );

endmodule

`default_nettype wire

//--- dv/game_model.svh
`ifndef GAME_MODEL_SVH
`define GAME_MODEL_SVH

localparam int MAP_TILES       = tile_pkg::TILE_COLS * tile_pkg::TILE_ROWS;
localparam int LAST_FLOOR_ADDR =
    (tile_pkg::FLOOR_ROW_FIRST + tile_pkg::FLOOR_ROWS) * tile_pkg::TILE_COLS - 1;

// shadow of the background map, rebuilt from the write port
tile_pkg::tile_word_t shadow_map [MAP_TILES];

int coin_addr    = -1;  // last coin draw
int coin_draws   = 0;
int coin_blanks  = 0;   // erases of the last drawn coin tile
int ghost_addr   = -1;
int ghost_draws  = 0;
int floor_sweeps = 0;

// delay between scroll steps for a given score
function automatic int scroll_delay(input int score_now);
    int d;
    d = game_pkg::SCROLL_DELAY_START
        - game_pkg::SCROLL_SPEED_STEP * (score_now / game_pkg::SPEEDUP_EVERY);
    if (d < game_pkg::SCROLL_DELAY_MIN) begin
        d = game_pkg::SCROLL_DELAY_MIN;
    end
    return d;
endfunction

// floor tile expected with the cliff at column gap
function automatic tile_pkg::tile_word_t floor_tile_for(input int gap, input int r,
                                                        input int c);
    if (c == gap - 4) begin
        return (r == 0) ? tile_pkg::CLIFF_LEFT_TOP : tile_pkg::CLIFF_LEFT_BODY;
    end
    if (c == gap - 3 || c == gap - 2) begin
        return tile_pkg::TILE_BLANK;
    end
    if (c == gap - 1) begin
        return (r == 0) ? tile_pkg::CLIFF_RIGHT_TOP : tile_pkg::CLIFF_RIGHT_BODY;
    end
    return (r == 0) ? tile_pkg::FLOOR_TOP : tile_pkg::FLOOR_FILL;
endfunction

function automatic bit gap_fits(input int gap);
    int a;
    for (int r = 0; r < tile_pkg::FLOOR_ROWS; r++) begin
        for (int c = 0; c < tile_pkg::TILE_COLS; c++) begin
            a = (tile_pkg::FLOOR_ROW_FIRST + r) * tile_pkg::TILE_COLS + c;
            if (shadow_map[a] != floor_tile_for(gap, r, c)) begin
                return 1'b0;
            end
        end
    end
    return 1'b1;
endfunction

// some single gap position explains all three rows
function automatic bit floor_intact();
    for (int g = 0; g <= tile_pkg::TILE_COLS + 4; g++) begin
        if (gap_fits(g)) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

task automatic note_write(input tile_pkg::tile_write_t w);
    int a;
    a = int'(w.addr);
    check_value("bg_write.addr below map size", a < MAP_TILES, 1);
    shadow_map[a] = w.word;
    if (w.word == tile_pkg::COIN_TILE) begin
        coin_addr = a;
        coin_draws++;
    end else if (w.word == tile_pkg::GHOST_TILE) begin
        ghost_addr = a;
        ghost_draws++;
    end else if (w.word == tile_pkg::TILE_BLANK && a == coin_addr) begin
        coin_blanks++;
    end
    if (a == LAST_FLOOR_ADDR) begin  // a sweep always ends here
        floor_sweeps++;
        check_value("floor rows gap pattern", floor_intact(), 1);
    end
endtask

`endif

//--- dv/game_engine_tb.sv
`default_nettype none

module game_engine_tb;

    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES  = 10;
    localparam int RANDOM_CYCLES = 8000;
    localparam int SPRITE_WAIT   = 2000;  // up to two tile steps
    localparam int HIT_WAIT      = 50;
    localparam int COIN_HOLD     = 400;
    localparam int FREEZE_HOLD   = 300;
    localparam int PHASE_CYCLES  = 4 * RESET_CYCLES + RANDOM_CYCLES + 2 * SPRITE_WAIT
                                   + 2 * HIT_WAIT + COIN_HOLD + 2 * FREEZE_HOLD;
    localparam int TIMEOUT_CYCLES = 4 * PHASE_CYCLES;

    logic                  clk;
    logic                  reset;
    logic                  game_on;
    game_pkg::player_pos_t player;
    logic                  bg_we;
    tile_pkg::tile_write_t bg_write;
    logic [3:0]            bg_x_offset;
    game_pkg::score_t      score;
    logic                  game_over;

    int seed        = 81;
    int cycle_count = 0;

    // scroll monitor state
    bit         was_running = 1'b0;
    logic [3:0] last_offset = '0;
    int         last_score  = 0;
    int         run_edges   = 0;
    int         expect_delay;

    game_engine i_dut (
        .clk, .reset, .game_on, .player, .bg_we, .bg_write, .bg_x_offset, .score, .game_over
    );

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("** Error at time %0t: %s = %0d, expected %0d",
                     $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    `include "game_model.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    // write tracking and scroll step spacing
    always @(negedge clk) begin
        if (reset) begin
            run_edges    = 0;
            expect_delay = scroll_delay(0);
        end else begin
            if (bg_we) begin
                note_write(bg_write);
            end
            if (!game_over) begin
                if (was_running) begin
                    run_edges++;
                end
                if (bg_x_offset != last_offset) begin
                    check_value("bg_x_offset moves only while running", was_running, 1);
                    check_value("bg_x_offset", bg_x_offset, (last_offset + 1) % 16);
                    check_value("bg_x_offset step spacing", run_edges, expect_delay + 1);
                    run_edges    = 0;
                    expect_delay = scroll_delay(last_score);  // score before the step
                end
            end
        end
        was_running = !reset && game_on && !game_over;
        last_offset = bg_x_offset;
        last_score  = int'(score);
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic place_player(input int x, input int y);
        player.x = 10'(x);
        player.y = 10'(y);
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) next_cycle();
        reset = 1'b0;
        check_value("bg_we", bg_we, 0);
        check_value("score", score, 0);
        check_value("game_over", game_over, 0);
        check_value("bg_x_offset", bg_x_offset, 0);
    endtask

    task automatic exercise_random_play();
        int sweeps_before;
        sweeps_before = floor_sweeps;
        game_on = 1'b1;
        place_player($unsigned($random(seed)) % 600, $unsigned($random(seed)) % 300);
        repeat (RANDOM_CYCLES) begin
            next_cycle();
            if (($random(seed) & 31) == 0) begin
                game_on = !game_on;
                place_player($unsigned($random(seed)) % 600, $unsigned($random(seed)) % 300);
            end
        end
        check_value("floor sweeps in random play", floor_sweeps - sweeps_before >= 2, 1);
    endtask

    task automatic eat_coin();
        int draws;
        int col;
        int row;
        int blanks;
        int score_before;
        bit usable;
        game_on = 1'b1;
        place_player(40, 200);
        usable = 1'b0;
        while (!usable) begin
            draws = coin_draws;
            while (coin_draws == draws) next_cycle();
            col    = coin_addr % tile_pkg::TILE_COLS;
            row    = coin_addr / tile_pkg::TILE_COLS;
            usable = (row < game_pkg::GHOST_ROW) && (col >= 1);  // clear of the ghost row
        end
        blanks       = coin_blanks;
        score_before = int'(score);
        place_player(col * tile_pkg::TILE_PX, row * tile_pkg::TILE_PX - 32);
        while (int'(score) == score_before) next_cycle();
        check_value("score", score, score_before + game_pkg::COIN_POINTS);
        while (coin_blanks == blanks) next_cycle();
        repeat (COIN_HOLD) begin
            next_cycle();
            check_value("score", score, score_before + game_pkg::COIN_POINTS);
        end
        place_player(40, 200);
    endtask

    task automatic hold_frozen();
        int frozen;
        frozen = int'(score);
        repeat (FREEZE_HOLD) begin
            next_cycle();
            check_value("game_over", game_over, 1);
            check_value("bg_x_offset", bg_x_offset, 0);
            check_value("score", score, frozen);
        end
    endtask

    task automatic touch_ghost();
        int draws;
        apply_reset();
        game_on = 1'b1;
        place_player(40, 200);
        draws = ghost_draws;
        while (ghost_draws == draws) next_cycle();
        place_player((ghost_addr % tile_pkg::TILE_COLS) * tile_pkg::TILE_PX,
                     (ghost_addr / tile_pkg::TILE_COLS) * tile_pkg::TILE_PX);
        while (!game_over) next_cycle();
        hold_frozen();
    endtask

    task automatic fall_off_screen();
        apply_reset();
        game_on = 1'b1;
        place_player(100, game_pkg::FALL_Y);
        while (!game_over) next_cycle();
        hold_frozen();
    endtask

    initial begin
        reset   = 1'b1;
        game_on = 1'b0;
        player  = '0;
        apply_reset();
        exercise_random_play();
        eat_coin();
        touch_ghost();
        fall_off_screen();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+dv
logic/tile_pkg.sv
logic/game_pkg.sv
logic/scroll_timer.sv
logic/floor_painter.sv
logic/sprite_mover.sv
logic/collision_judge.sv
logic/bg_write_arbiter.sv
logic/game_engine.sv
dv/game_engine_tb.sv
